//--- gfx_pkg.sv
package gfx_pkg;

	// ----------------------------------------
	// Lane geometry
	// ----------------------------------------

	localparam int SHADER_LANES = 4;
	localparam int WORD_BITS    = 32;
	localparam int SHAMT_BITS   = 5;

	typedef logic signed [WORD_BITS-1:0] word;   // Two's complement lane value

	typedef word [SHADER_LANES-1:0] lanes_t;

	// ----------------------------------------
	// Operation control
	// ----------------------------------------

	// Conditioning order is swap, abs, zero_b
	typedef struct packed {
		logic                  swap;
		logic                  abs;
		logic                  zero_b;
		logic                  sub;
		logic                  shift_en;
		logic                  shift_signed;   // Arithmetic shift when set
		logic [SHAMT_BITS-1:0] shamt;
		logic                  clamp;          // Applied after the shift
	} fpint_op;

	// ----------------------------------------
	// Stage payloads
	// ----------------------------------------

	// Setup to add/subtract
	typedef struct packed {
		fpint_op op;
		lanes_t  a;
		lanes_t  b;
	} setup_out_t;

	// Add/subtract to shift
	typedef struct packed {
		fpint_op op;
		lanes_t  lanes;
	} addsub_out_t;

endpackage

//--- gfx_fpint_setup.sv
`timescale 1ns/10ps

module gfx_fpint_setup (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                in_valid,
	input  gfx_pkg::fpint_op    op,
	input  gfx_pkg::lanes_t     a,
	input  gfx_pkg::lanes_t     b,
	output logic                setup_valid,
	output gfx_pkg::setup_out_t setup
);

	import gfx_pkg::*;

	lanes_t swap_a;
	lanes_t swap_b;
	lanes_t abs_a;
	lanes_t abs_b;
	lanes_t cond_b;

	// Wraps, so the most negative word maps to itself
	function automatic word magnitude(input word value);
		word result;
		if (value[WORD_BITS-1]) begin
			result = -value;
		end else begin
			result = value;
		end
		return result;
	endfunction

	// ----------------------------------------
	// Operand conditioning
	// ----------------------------------------

	always_comb begin
		for (int i = 0; i < SHADER_LANES; i++) begin
			if (op.swap) begin
				swap_a[i] = b[i];
				swap_b[i] = a[i];
			end else begin
				swap_a[i] = a[i];
				swap_b[i] = b[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < SHADER_LANES; i++) begin
			if (op.abs) begin
				abs_a[i] = magnitude(swap_a[i]);
				abs_b[i] = magnitude(swap_b[i]);
			end else begin
				abs_a[i] = swap_a[i];
				abs_b[i] = swap_b[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < SHADER_LANES; i++) begin
			cond_b[i] = op.zero_b ? '0 : abs_b[i];   // Turns an add into a move of a
		end
	end

	// ----------------------------------------
	// Stage register
	// ----------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			setup_valid <= 1'b0;
		end else begin
			setup_valid <= in_valid;
		end
	end

	// Payload only moves with a strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			setup.op <= op;
			setup.a  <= abs_a;
			setup.b  <= cond_b;
		end
	end

endmodule

//--- gfx_fpint_addsub.sv
`timescale 1ns/10ps

module gfx_fpint_addsub (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 setup_valid,
	input  gfx_pkg::setup_out_t  setup,
	output logic                 sum_valid,
	output gfx_pkg::addsub_out_t sum
);

	import gfx_pkg::*;

	lanes_t sum_lanes;
	lanes_t operand_b;

	// ----------------------------------------
	// Per-lane adder
	// ----------------------------------------

	// Subtract as a plus inverted b plus one
	always_comb begin
		for (int i = 0; i < SHADER_LANES; i++) begin
			if (setup.op.sub) begin
				operand_b[i] = ~setup.b[i];
			end else begin
				operand_b[i] = setup.b[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < SHADER_LANES; i++) begin
			// Carry out dropped, result wraps mod 2^32
			sum_lanes[i] = setup.a[i] + operand_b[i] + word'(setup.op.sub);
		end
	end

	// ----------------------------------------
	// Stage register
	// ----------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= setup_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (setup_valid) begin
			sum.op    <= setup.op;   // Shift and clamp bits still needed downstream
			sum.lanes <= sum_lanes;
		end
	end

endmodule

//--- gfx_fpint_shift.sv
`timescale 1ns/10ps

module gfx_fpint_shift (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 sum_valid,
	input  gfx_pkg::addsub_out_t sum,
	output logic                 out_valid,
	output gfx_pkg::lanes_t      q
);

	import gfx_pkg::*;

	lanes_t arith;
	lanes_t logic_sh;
	lanes_t shifted;
	lanes_t clamped;

	// ----------------------------------------
	// Right shift
	// ----------------------------------------

	always_comb begin
		for (int i = 0; i < SHADER_LANES; i++) begin
			arith[i]    = $signed(sum.lanes[i]) >>> sum.op.shamt;   // Sign fill
			logic_sh[i] = $unsigned(sum.lanes[i]) >> sum.op.shamt;  // Zero fill
		end
	end

	always_comb begin
		for (int i = 0; i < SHADER_LANES; i++) begin
			if (!sum.op.shift_en) begin
				shifted[i] = sum.lanes[i];
			end else if (sum.op.shift_signed) begin
				shifted[i] = arith[i];
			end else begin
				shifted[i] = logic_sh[i];
			end
		end
	end

	// ----------------------------------------
	// Clamp at zero
	// ----------------------------------------

	always_comb begin
		for (int i = 0; i < SHADER_LANES; i++) begin
			if (sum.op.clamp && shifted[i][WORD_BITS-1]) begin
				clamped[i] = '0;
			end else begin
				clamped[i] = shifted[i];
			end
		end
	end

	// ----------------------------------------
	// Writeback register
	// ----------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= sum_valid;
		end
	end

	// Holds the last result between strobes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (sum_valid) begin
			q <= clamped;
		end
	end

endmodule

//--- gfx_fpint.sv
`timescale 1ns/10ps

module gfx_fpint (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             in_valid,
	input  gfx_pkg::fpint_op op,
	input  gfx_pkg::lanes_t  a,
	input  gfx_pkg::lanes_t  b,
	output logic             out_valid,
	output gfx_pkg::lanes_t  q
);

	import gfx_pkg::*;

	logic        setup_valid;
	setup_out_t  setup_data;

	logic        sum_valid;
	addsub_out_t sum_data;

	// ----------------------------------------
	// Stage 1, operand setup
	// ----------------------------------------

	gfx_fpint_setup setup (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_valid    (in_valid),
		.op          (op),
		.a           (a),
		.b           (b),
		.setup_valid (setup_valid),
		.setup       (setup_data)
	);

	// ----------------------------------------
	// Stage 2, add or subtract
	// ----------------------------------------

	gfx_fpint_addsub addsub (
		.clk         (clk),
		.arst_n      (arst_n),
		.setup_valid (setup_valid),
		.setup       (setup_data),
		.sum_valid   (sum_valid),
		.sum         (sum_data)
	);

	// ----------------------------------------
	// Stage 3, shift, clamp and writeback
	// ----------------------------------------

	gfx_fpint_shift shift (
		.clk       (clk),
		.arst_n    (arst_n),
		.sum_valid (sum_valid),
		.sum       (sum_data),
		.out_valid (out_valid),   // Three cycles after in_valid
		.q         (q)
	);

endmodule

//--- gfx_fpint_asserts.sv
`timescale 1ns/10ps

module gfx_fpint_asserts (
	input logic            clk,
	input logic            arst_n,
	input logic            in_valid,
	input logic            out_valid,
	input gfx_pkg::lanes_t q
);

	logic [2:0] strobe_hist;   // in_valid over the last three edges

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			strobe_hist <= '0;
		end else begin
			strobe_hist <= {strobe_hist[1:0], in_valid};
		end
	end

	// ----------------------------------------
	// Properties
	// ----------------------------------------

	reset_state: assert property (@(posedge clk) !arst_n |-> (!out_valid && q == '0))
		else $error("out_valid or q not cleared during reset");

	// Every strobe gives one result
	strobe_to_result: assert property (@(posedge clk) disable iff (!arst_n)
		strobe_hist[2] |-> out_valid)
		else $error("in_valid not followed by out_valid three cycles later");

	// Also keeps out_valid low right after reset
	no_stray_result: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> strobe_hist[2])
		else $error("out_valid without a matching in_valid");

endmodule

bind gfx_fpint gfx_fpint_asserts strobe_checks (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.q         (q)
);

//--- gfx_fpint_tb.sv
`timescale 1ns/10ps

module gfx_fpint_tb;

	import gfx_pkg::*;

	localparam int    RESET_CYCLES = 10;
	localparam int    LATENCY      = 3;
	localparam int    MAX_GAP      = 3;
	localparam int    MARGIN       = 20;
	localparam string CASE_FILE    = "fpint_cases.txt";

	logic    clk;
	logic    arst_n;
	logic    in_valid;
	fpint_op op;
	lanes_t  a;
	lanes_t  b;
	logic    out_valid;
	lanes_t  q;

	// Case table with one entry per file line
	fpint_op case_op[$];
	lanes_t  case_a[$];
	lanes_t  case_b[$];
	lanes_t  case_q[$];
	int      gap[$];

	lanes_t  pend_q[$];     // Expected results in flight
	int      pend_idx[$];

	int cycles;
	int cycle_limit;
	int sent;
	int received;
	int out_count;
	int pass_count;
	int error_count;

	gfx_fpint UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.q         (q)
	);

	always #5 clk = ~clk;

	// ----------------------------------------
	// Case file
	// ----------------------------------------

	task automatic load_cases();
		int          fd;
		int          fields;
		string       line;
		logic [31:0] f [20];
		fpint_op     op_v;
		lanes_t      a_v;
		lanes_t      b_v;
		lanes_t      q_v;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open %s", CASE_FILE);
			error_count++;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin   // Skip comments and blanks
					fields = $sscanf(line,
						"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
						f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
					if (fields != 20) begin
						$display("Malformed line in %s: %s", CASE_FILE, line);
						error_count++;
					end else begin
						op_v.swap         = f[0][0];
						op_v.abs          = f[1][0];
						op_v.zero_b       = f[2][0];
						op_v.sub          = f[3][0];
						op_v.shift_en     = f[4][0];
						op_v.shift_signed = f[5][0];
						op_v.shamt        = f[6][SHAMT_BITS-1:0];
						op_v.clamp        = f[7][0];
						for (int i = 0; i < SHADER_LANES; i++) begin
							a_v[i] = f[8+i];
							b_v[i] = f[12+i];
							q_v[i] = f[16+i];
						end
						case_op.push_back(op_v);
						case_a.push_back(a_v);
						case_b.push_back(b_v);
						case_q.push_back(q_v);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------

	task automatic drive_case(input int idx);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		op       = case_op[idx];
		a        = case_a[idx];
		b        = case_b[idx];
		pend_q.push_back(case_q[idx]);
		pend_idx.push_back(idx);
		sent++;
	endtask

	task automatic drive_idle(input int count);
		repeat (count) begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
		end
	endtask

	// ----------------------------------------
	// Output checks
	// ----------------------------------------

	// Sampled at the falling edge away from register updates
	always @(negedge clk) begin
		lanes_t want;
		int     idx;
		logic   good;
		if (arst_n && out_valid) begin
			out_count++;
			if (pend_q.size() == 0) begin
				$display("out_valid was high with no case pending");
				error_count++;
			end else begin
				want = pend_q.pop_front();
				idx  = pend_idx.pop_front();
				good = 1'b1;
				for (int i = 0; i < SHADER_LANES; i++) begin
					if (q[i] !== want[i]) begin
						$display("CHECK FAILED case %0d q[%0d]: expected 0x%08h, got 0x%08h",
							idx, i, want[i], q[i]);
						good = 1'b0;
					end
				end
				received++;
				if (good) begin
					pass_count++;
					$display("result %0d (case %0d): ok", received, idx);
				end else begin
					error_count++;
					$display("result %0d (case %0d): FAILED", received, idx);
				end
			end
		end else if (arst_n && received == 0 && q !== '0) begin
			$display("CHECK FAILED q after reset: expected 0x%032h, got 0x%032h", 128'h0, q);
			error_count++;
		end
	end

	// Run limit
	initial begin
		do begin
			@(posedge clk);
			cycles++;
		end while (cycles <= cycle_limit);
		$display("Timeout after %0d cycles, %0d of %0d results seen", cycles, received, sent);
		$display("Errors found");
		$finish;
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial begin
		int gap_total;
		clk         = 1'b0;
		arst_n      = 1'b0;
		in_valid    = 1'b0;
		op          = '0;
		a           = '0;
		b           = '0;
		cycles      = 0;
		sent        = 0;
		received    = 0;
		out_count   = 0;
		pass_count  = 0;
		error_count = 0;
		gap_total   = 0;
		void'($urandom(32'h89e7));
		load_cases();
		foreach (case_op[i]) begin
			gap.push_back(int'($urandom % (MAX_GAP + 1)));
			gap_total += gap[i];
		end
		// Both passes plus latency and idle gaps
		cycle_limit = RESET_CYCLES + 2 * case_op.size() + LATENCY + gap_total + MARGIN;

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;

		foreach (case_op[i]) begin
			drive_case(i);   // Back to back
		end
		foreach (case_op[i]) begin
			drive_idle(gap[i]);
			drive_case(i);
		end
		drive_idle(1);
		wait (received == sent);
		drive_idle(LATENCY + 2);   // Room for a stray strobe

		if (case_op.size() == 0) begin
			$display("No cases were read from %s", CASE_FILE);
			error_count++;
		end
		if (out_count != 2 * case_op.size()) begin
			$display("Expected %0d results but saw %0d", 2 * case_op.size(), out_count);
			error_count++;
		end
		$display("%0d results checked, %0d passed, %0d failed", received, pass_count, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- fpint_cases.txt
# swap abs zero_b sub shift_en shift_signed shamt clamp, a0 a1 a2 a3, b0 b1 b2 b3, q0 q1 q2 q3
# All fields hex, lane 0 first in each group
0 0 0 0 0 0 00 0 1 2 3 4 10 20 30 40 11 22 33 44
0 0 0 0 0 0 00 0 ffffffff 7fffffff 80000000 12345678 1 1 80000000 edcba988 0 80000000 0 0
0 0 0 0 0 0 00 0 deadbeef 0 fffffff0 100 11111111 0 20 ffffff00 efbed000 0 10 0
0 0 0 1 0 0 00 0 10 5 0 80000000 3 5 1 1 d 0 ffffffff 7fffffff
0 0 0 1 0 0 00 0 1000 ffffffff 7fffffff 0 1 ffffffff ffffffff 80000000 fff 0 80000000 80000000
1 0 0 1 0 0 00 0 10 5 0 64 3 7 1 c8 fffffff3 2 1 64
1 0 0 0 0 0 00 0 1 2 3 4 5 6 7 8 6 8 a c
0 1 0 0 0 0 00 0 fffffffb 3 80000000 ffffffff fffffffe fffffff9 1 ffffffff 7 a 80000001 2
0 1 0 1 0 0 00 0 ffffff9c 80000000 a fffffff6 32 80000000 fffffff6 14 32 0 0 fffffff6
0 0 1 0 0 0 00 0 12345678 ffffffff 80000000 0 11111111 22 33 44 12345678 ffffffff 80000000 0
0 0 1 1 0 0 00 0 abcdef01 5 0 7fffffff 1 2 3 4 abcdef01 5 0 7fffffff
1 0 1 0 0 0 00 0 1 2 3 4 aaaa bbbb cccc dddd aaaa bbbb cccc dddd
1 1 0 1 0 0 00 0 fffffff0 0 80000000 5 ffffffe0 ffffffff 3 fffffffd 10 1 80000003 fffffffe
0 1 1 0 0 0 00 0 ffffffff 80000000 7fffffff fffffc18 9 9 9 9 1 80000000 7fffffff 3e8
0 0 0 1 1 0 04 0 0 0 100 ffffffff 10 1 0 0 fffffff fffffff 10 fffffff
0 0 0 1 1 1 04 0 0 0 100 ffffffff 10 1 0 0 ffffffff ffffffff 10 ffffffff
0 0 0 0 1 1 00 0 80000000 1 ffff 7fffffff 0 0 0 0 80000000 1 ffff 7fffffff
0 0 0 0 1 0 00 0 deadbeef 80000001 0 2 1 0 0 0 deadbef0 80000001 0 2
0 0 0 0 1 0 1f 0 80000000 ffffffff 7fffffff 1 0 0 0 0 1 1 0 0
0 0 0 0 1 1 1f 0 80000000 ffffffff 7fffffff 1 0 0 0 0 ffffffff ffffffff 0 0
0 0 0 0 1 1 08 0 12345678 ff000000 80 fffff000 0 0 80 0 123456 ffff0000 1 fffffff0
0 0 0 0 1 0 01 0 3 fffffffe 80000000 10 0 0 0 0 1 7fffffff 40000000 8
0 0 0 0 0 0 00 1 ffffffff 5 80000000 7fffffff 0 0 0 0 0 5 0 7fffffff
0 0 0 1 0 0 00 1 1 10 0 80000000 2 1 0 1 0 f 0 7fffffff
0 0 0 0 1 1 04 1 fffffff0 100 80000000 7ffffff0 0 0 0 0 0 10 0 7ffffff
0 0 0 0 1 0 04 1 fffffff0 100 80000000 7ffffff0 0 0 0 0 fffffff 10 8000000 7ffffff
0 0 0 0 1 0 00 1 80000000 ffffffff 1 0 0 0 0 0 0 0 1 0
1 1 0 1 1 1 02 1 fffffff8 4 64 fffffffc 4 fffffff0 8 c 0 3 0 2
0 1 0 0 1 0 01 0 fffffffe 80000000 fffffffb ffffff00 0 0 fffffffb 0 1 40000000 5 80
0 0 1 0 1 1 03 0 ffffff80 40 fffffff9 7 ffff ffff ffff ffff fffffff0 8 ffffffff 0
0 0 0 0 1 0 10 0 ffff0000 7fffffff 12340000 0 20000 1 5678 ffffffff 1 8000 1234 ffff
0 0 0 1 1 1 10 0 0 0 12345678 80000000 10000 1 0 1 ffffffff ffffffff 1234 7fff

//--- filelist.f
gfx_pkg.sv
gfx_fpint_setup.sv
gfx_fpint_addsub.sv
gfx_fpint_shift.sv
gfx_fpint.sv
gfx_fpint_asserts.sv
gfx_fpint_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module gfx_fpint_tb -f filelist.f -o gfx_fpint_sim

output=$(./obj_dir/gfx_fpint_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1
